/* hdl/tile_accel_settings.svh */
`ifndef TILE_ACCEL_SETTINGS_SVH
`define TILE_ACCEL_SETTINGS_SVH

// Job dimensions and bus widths
`define TILE_DIM_W      8
`define TILE_ADDR_W     32
`define TILE_DATA_W     32

// Output tile geometry and spacing in bytes
`define TILE_ROWS       4
`define TILE_COLS       8
`define TILE_STRIDE     64

// Command buffer depth, also the initial credit count
`define TILE_FIFO_DEPTH 4

// Register word address width
`define TILE_REG_AW     3

`endif

/* hdl/tile_bus_pkg.sv */
`include "tile_accel_settings.svh"

package tile_bus_pkg;

  typedef logic [`TILE_REG_AW-1:0] reg_addr_t;
  typedef logic [`TILE_DATA_W-1:0] data_t;

  // Request side, wen high means read
  typedef struct packed {
    logic      req;
    logic      wen;
    reg_addr_t addr;
    data_t     wdata;
  } periph_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } periph_rsp_t;

  // Register map, word offsets
  localparam reg_addr_t REG_TRIGGER    = reg_addr_t'(0);
  localparam reg_addr_t REG_STATUS     = reg_addr_t'(1);
  localparam reg_addr_t REG_M          = reg_addr_t'(2);
  localparam reg_addr_t REG_N          = reg_addr_t'(3);
  localparam reg_addr_t REG_K          = reg_addr_t'(4);
  localparam reg_addr_t REG_BASE       = reg_addr_t'(5);
  localparam reg_addr_t REG_TILE_COUNT = reg_addr_t'(6);
  localparam reg_addr_t REG_SOFT_CLEAR = reg_addr_t'(7);

endpackage

/* hdl/tile_job_pkg.sv */
`include "tile_accel_settings.svh"

package tile_job_pkg;

  typedef logic [`TILE_DIM_W-1:0]  dim_t;
  typedef logic [`TILE_ADDR_W-1:0] addr_t;
  typedef logic [`TILE_DIM_W-1:0]  tile_idx_t;

  // Holds 0 up to TILE_FIFO_DEPTH inclusive
  typedef logic [$clog2(`TILE_FIFO_DEPTH):0] credit_t;

  typedef struct packed {
    dim_t  m;
    dim_t  n;
    dim_t  k;
    addr_t base;
  } job_cfg_t;

  typedef struct packed {
    tile_idx_t row;
    tile_idx_t col;
    addr_t     addr;
    dim_t      k;
    logic      last;
  } tile_cmd_t;

  typedef struct packed {
    tile_idx_t row;
    tile_idx_t col;
    addr_t     addr;
  } tile_result_t;

  typedef enum logic [2:0] {
    CTRL_LATCH_RST,
    CTRL_IDLE,
    CTRL_STARTING,
    CTRL_RUNNING,
    CTRL_FINISHED
  } ctrl_state_e;

endpackage

/* hdl/tile_regfile.sv */
`timescale 1ns/10ps

module tile_regfile (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  tile_bus_pkg::periph_req_t periph_req_i,
  output tile_bus_pkg::periph_rsp_t periph_rsp_o,
  input  logic                      busy_i,
  input  logic                      clear_i,
  input  logic                      setback_i,
  input  logic                      tile_done_i,
  output tile_job_pkg::job_cfg_t    cfg_o,
  output logic                      start_req_o,
  output logic                      soft_clear_o
);
  import tile_bus_pkg::*;
  import tile_job_pkg::*;

  job_cfg_t cfg_q;
  data_t    tile_cnt_q;
  data_t    rdata_d;
  data_t    rdata_q;
  logic     rvalid_q;
  logic     start_q;
  logic     wr_en;
  logic     rd_en;

  assign wr_en = periph_req_i.req & ~periph_req_i.wen;
  assign rd_en = periph_req_i.req & periph_req_i.wen;

  // Job registers, status and count are read only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (periph_req_i.addr)
        REG_M:    cfg_q.m    <= dim_t'(periph_req_i.wdata);
        REG_N:    cfg_q.n    <= dim_t'(periph_req_i.wdata);
        REG_K:    cfg_q.k    <= dim_t'(periph_req_i.wdata);
        REG_BASE: cfg_q.base <= addr_t'(periph_req_i.wdata);
        default: ;
      endcase
    end
  end

  // Start latch, held until the controller takes the job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else if (clear_i || setback_i) begin
      start_q <= 1'b0;
    end else if (wr_en && periph_req_i.addr == REG_TRIGGER) begin
      start_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_cnt_q <= '0;
    end else if (setback_i) begin
      tile_cnt_q <= '0;
    end else if (tile_done_i) begin
      tile_cnt_q <= tile_cnt_q + data_t'(1);
    end
  end

  always_comb begin
    rdata_d = '0;
    case (periph_req_i.addr)
      REG_STATUS:     rdata_d[0] = busy_i;
      REG_M:          rdata_d    = data_t'(cfg_q.m);
      REG_N:          rdata_d    = data_t'(cfg_q.n);
      REG_K:          rdata_d    = data_t'(cfg_q.k);
      REG_BASE:       rdata_d    = data_t'(cfg_q.base);
      REG_TILE_COUNT: rdata_d    = tile_cnt_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  // Every request is granted at once
  assign periph_rsp_o.gnt     = periph_req_i.req;
  assign periph_rsp_o.r_valid = rvalid_q;
  assign periph_rsp_o.r_data  = rdata_q;

  assign cfg_o        = cfg_q;
  assign start_req_o  = start_q;
  assign soft_clear_o = wr_en && (periph_req_i.addr == REG_SOFT_CLEAR);

  a_rvalid_after_read : assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_rsp_o.r_valid |-> $past(periph_req_i.req && periph_req_i.wen && periph_rsp_o.gnt));

endmodule

/* hdl/tile_ctrl_fsm.sv */
`timescale 1ns/10ps

module tile_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tile_job_pkg::job_cfg_t cfg_i,
  input  logic                   start_req_i,
  input  logic                   soft_clear_i,
  input  logic                   last_done_i,
  output logic                   gen_start_o,
  output logic                   setback_o,
  output logic                   clear_o,
  output logic                   busy_o,
  output logic                   evt_o
);
  import tile_job_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        empty_job;

  // No tile to compute when either output dimension is zero
  assign empty_job = (cfg_i.m == '0) || (cfg_i.n == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_LATCH_RST;
    end else if (soft_clear_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_LATCH_RST: begin
        state_d = CTRL_IDLE;
      end
      CTRL_IDLE: begin
        if (start_req_i) begin
          state_d = empty_job ? CTRL_FINISHED : CTRL_STARTING;
        end
      end
      CTRL_STARTING: begin
        state_d = CTRL_RUNNING;
      end
      CTRL_RUNNING: begin
        if (last_done_i) begin
          state_d = CTRL_FINISHED;
        end
      end
      CTRL_FINISHED: begin
        state_d = CTRL_IDLE;
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  // Taking the job drops the start latch, empty jobs included
  assign setback_o   = (state_q == CTRL_IDLE) && start_req_i;
  assign gen_start_o = (state_q == CTRL_STARTING);
  assign busy_o      = (state_q == CTRL_STARTING) || (state_q == CTRL_RUNNING);
  assign evt_o       = (state_q == CTRL_FINISHED);
  assign clear_o     = soft_clear_i || (state_q == CTRL_LATCH_RST);

  a_evt_not_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_o |-> !busy_o ##1 !evt_o);

endmodule

/* hdl/tile_cmd_gen.sv */
`timescale 1ns/10ps
`include "tile_accel_settings.svh"

module tile_cmd_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    gen_start_i,
  input  tile_job_pkg::job_cfg_t  cfg_i,
  input  logic                    credit_i,
  output logic                    cmd_valid_o,
  output tile_job_pkg::tile_cmd_t cmd_o
);
  import tile_job_pkg::*;

  logic      active_q;
  tile_idx_t row_q;
  tile_idx_t col_q;
  tile_idx_t rows_total_q;
  tile_idx_t cols_total_q;
  dim_t      k_q;
  addr_t     base_q;
  credit_t   credit_q;
  addr_t     tile_lin;
  logic      last_col;
  logic      last_row;
  logic      issue;

  // Grid size is latched together with the job
  always_ff @(posedge clk_i) begin
    if (gen_start_i) begin
      rows_total_q <= tile_idx_t'((int'(cfg_i.m) + `TILE_ROWS - 1) / `TILE_ROWS);
      cols_total_q <= tile_idx_t'((int'(cfg_i.n) + `TILE_COLS - 1) / `TILE_COLS);
      k_q          <= cfg_i.k;
      base_q       <= cfg_i.base;
    end
  end

  assign last_col = (col_q == cols_total_q - tile_idx_t'(1));
  assign last_row = (row_q == rows_total_q - tile_idx_t'(1));
  assign issue    = cmd_valid_o;

  // Rows outer, columns inner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      row_q    <= '0;
      col_q    <= '0;
    end else if (clear_i) begin
      active_q <= 1'b0;
    end else if (gen_start_i) begin
      active_q <= 1'b1;
      row_q    <= '0;
      col_q    <= '0;
    end else if (issue) begin
      if (last_col) begin
        col_q <= '0;
        if (last_row) begin
          active_q <= 1'b0;
        end else begin
          row_q <= row_q + tile_idx_t'(1);
        end
      end else begin
        col_q <= col_q + tile_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= credit_t'(`TILE_FIFO_DEPTH);
    end else if (clear_i) begin
      credit_q <= credit_t'(`TILE_FIFO_DEPTH);
    end else begin
      credit_q <= credit_q - credit_t'(issue) + credit_t'(credit_i);
    end
  end

  assign tile_lin = addr_t'(row_q) * addr_t'(cols_total_q) + addr_t'(col_q);

  // Command held steady while out of credits
  assign cmd_valid_o = active_q && (credit_q != '0);
  assign cmd_o.row   = row_q;
  assign cmd_o.col   = col_q;
  assign cmd_o.addr  = base_q + tile_lin * addr_t'(`TILE_STRIDE);
  assign cmd_o.k     = k_q;
  assign cmd_o.last  = last_row && last_col;

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_t'(`TILE_FIFO_DEPTH));

endmodule

/* hdl/tile_cmd_fifo.sv */
`timescale 1ns/10ps
`include "tile_accel_settings.svh"

module tile_cmd_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    wr_valid_i,
  input  tile_job_pkg::tile_cmd_t wr_cmd_i,
  output logic                    wr_credit_o,
  input  logic                    rd_credit_i,
  output logic                    rd_valid_o,
  output tile_job_pkg::tile_cmd_t rd_cmd_o
);
  import tile_job_pkg::*;

  localparam int unsigned PtrW = $clog2(`TILE_FIFO_DEPTH);

  tile_cmd_t       mem_q [`TILE_FIFO_DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  credit_t         count_q;
  logic            credit_q;

  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem_q[wr_ptr_q] <= wr_cmd_i;
    end
  end

  // Engine credit pulse retires the head entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (wr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`TILE_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_credit_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`TILE_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + credit_t'(wr_valid_i) - credit_t'(rd_credit_i);
      credit_q <= rd_credit_i;
    end
  end

  assign wr_credit_o = credit_q;
  assign rd_valid_o  = (count_q != '0);
  assign rd_cmd_o    = mem_q[rd_ptr_q];

  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_i |-> count_q < credit_t'(`TILE_FIFO_DEPTH));

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_credit_i |-> count_q != '0);

endmodule

/* hdl/tile_engine.sv */
`timescale 1ns/10ps

module tile_engine (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       stall_i,
  input  logic                       cmd_valid_i,
  input  tile_job_pkg::tile_cmd_t    cmd_i,
  output logic                       credit_o,
  output logic                       result_valid_o,
  output tile_job_pkg::tile_result_t result_o,
  output logic                       last_done_o
);
  import tile_job_pkg::*;

  logic      busy_q;
  dim_t      cnt_q;
  tile_cmd_t cmd_q;
  logic      load;
  logic      done;

  assign load = !busy_q && cmd_valid_i && !stall_i;
  // Final cycle of the tile
  assign done = busy_q && !stall_i && (cnt_q == dim_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
    end else if (load) begin
      busy_q <= 1'b1;
      cnt_q  <= (cmd_i.k == '0) ? dim_t'(1) : cmd_i.k;
    end else if (busy_q && !stall_i) begin
      if (done) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - dim_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      cmd_q <= cmd_i;
    end
  end

  assign result_valid_o = done;
  assign credit_o       = done;
  assign last_done_o    = done && cmd_q.last;
  assign result_o.row   = cmd_q.row;
  assign result_o.col   = cmd_q.col;
  assign result_o.addr  = cmd_q.addr;

endmodule

/* hdl/tile_accel_top.sv */
`timescale 1ns/10ps

module tile_accel_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  tile_bus_pkg::periph_req_t  periph_req_i,
  output tile_bus_pkg::periph_rsp_t  periph_rsp_o,
  input  logic                       stall_i,
  output tile_job_pkg::tile_result_t result_o,
  output logic                       result_valid_o,
  output logic                       busy_o,
  output logic                       evt_o
);
  import tile_job_pkg::*;

  job_cfg_t  cfg;
  logic      start_req;
  logic      soft_clear;
  logic      setback;
  logic      clear;
  logic      gen_start;
  logic      last_done;
  logic      gen_valid;
  logic      gen_credit;
  tile_cmd_t gen_cmd;
  logic      eng_valid;
  logic      eng_credit;
  tile_cmd_t eng_cmd;

  tile_regfile i_regfile (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .periph_req_i ( periph_req_i   ),
    .periph_rsp_o ( periph_rsp_o   ),
    .busy_i       ( busy_o         ),
    .clear_i      ( clear          ),
    .setback_i    ( setback        ),
    .tile_done_i  ( result_valid_o ),
    .cfg_o        ( cfg            ),
    .start_req_o  ( start_req      ),
    .soft_clear_o ( soft_clear     )
  );

  tile_ctrl_fsm i_ctrl_fsm (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .cfg_i        ( cfg        ),
    .start_req_i  ( start_req  ),
    .soft_clear_i ( soft_clear ),
    .last_done_i  ( last_done  ),
    .gen_start_o  ( gen_start  ),
    .setback_o    ( setback    ),
    .clear_o      ( clear      ),
    .busy_o       ( busy_o     ),
    .evt_o        ( evt_o      )
  );

  tile_cmd_gen i_cmd_gen (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .clear_i     ( clear      ),
    .gen_start_i ( gen_start  ),
    .cfg_i       ( cfg        ),
    .credit_i    ( gen_credit ),
    .cmd_valid_o ( gen_valid  ),
    .cmd_o       ( gen_cmd    )
  );

  tile_cmd_fifo i_cmd_fifo (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .clear_i     ( clear      ),
    .wr_valid_i  ( gen_valid  ),
    .wr_cmd_i    ( gen_cmd    ),
    .wr_credit_o ( gen_credit ),
    .rd_credit_i ( eng_credit ),
    .rd_valid_o  ( eng_valid  ),
    .rd_cmd_o    ( eng_cmd    )
  );

  tile_engine i_engine (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear          ),
    .stall_i        ( stall_i        ),
    .cmd_valid_i    ( eng_valid      ),
    .cmd_i          ( eng_cmd        ),
    .credit_o       ( eng_credit     ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o       ),
    .last_done_o    ( last_done      )
  );

endmodule

/* dv/tile_accel_tb.sv */
`timescale 1ns/10ps
`include "tile_accel_settings.svh"

module tile_accel_tb;
  import tile_bus_pkg::*;
  import tile_job_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_K      = 8;
  localparam int MAX_STALL  = 12;
  localparam int N_STALLS   = 4;
  // Tiles over all jobs plus the quiet wait after the soft clear
  localparam int ALL_TILES   = 4 + 4 + 16 + 16 + 16 + 4;
  localparam int JOB_CYCLES  = ALL_TILES * (MAX_K + 1) + N_STALLS * (MAX_STALL + 6);
  localparam int TEST_CYCLES = 6 * 80 + 10;
  localparam int WATCHDOG_NS = 2 * (JOB_CYCLES + TEST_CYCLES) * CLK_PERIOD;

  logic         clk;
  logic         rst_n;
  logic         stall;
  periph_req_t  bus_req;
  periph_rsp_t  bus_rsp;
  tile_result_t result;
  logic         result_valid;
  logic         busy;
  logic         evt;

  tile_result_t res_q[$];
  tile_result_t exp_q[$];
  int           evt_cnt;
  int           res_at_evt;
  logic         busy_at_evt;
  int           seed;
  int           errors;
  int           checks;
  int           tests;
  int           test_err_base;

  tile_accel_top i_tile_accel_top (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .periph_req_i   ( bus_req      ),
    .periph_rsp_o   ( bus_rsp      ),
    .stall_i        ( stall        ),
    .result_o       ( result       ),
    .result_valid_o ( result_valid ),
    .busy_o         ( busy         ),
    .evt_o          ( evt          )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  // Results and end events as the host sees them
  always @(posedge clk) begin
    if (result_valid) begin
      res_q.push_back(result);
    end
    if (evt) begin
      evt_cnt++;
      res_at_evt  = res_q.size();
      busy_at_evt = busy;
    end
  end

  task automatic check_that(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("FAIL @%0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == test_err_base) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests, name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  task automatic write_reg(input reg_addr_t addr, input data_t data);
    @(negedge clk);
    bus_req.req   = 1'b1;
    bus_req.wen   = 1'b0;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    @(negedge clk);
    bus_req = '0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output data_t data);
    @(negedge clk);
    bus_req.req   = 1'b1;
    bus_req.wen   = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = '0;
    #1;
    check_that(bus_rsp.gnt, "read request not granted in its own cycle");
    @(negedge clk);
    bus_req = '0;
    check_that(bus_rsp.r_valid, "no r_valid one cycle after the read grant");
    data = bus_rsp.r_data;
  endtask

  task automatic expect_reg(input reg_addr_t addr, input data_t exp, input string name);
    data_t val;
    read_reg(addr, val);
    check_that(val == exp, $sformatf("%s reads %h, expected %h", name, val, exp));
  endtask

  // Raster order tile list with rows outer and columns inner
  task automatic build_expected(input int m, input int n, input addr_t base);
    int           rows;
    int           cols;
    tile_result_t t;
    rows = (m + `TILE_ROWS - 1) / `TILE_ROWS;
    cols = (n + `TILE_COLS - 1) / `TILE_COLS;
    exp_q.delete();
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        t.row  = tile_idx_t'(r);
        t.col  = tile_idx_t'(c);
        t.addr = base + addr_t'((r * cols + c) * `TILE_STRIDE);
        exp_q.push_back(t);
      end
    end
  endtask

  task automatic compare_results();
    check_that(res_q.size() == exp_q.size(),
      $sformatf("got %0d results, expected %0d", res_q.size(), exp_q.size()));
    for (int i = 0; i < exp_q.size() && i < res_q.size(); i++) begin
      check_that(res_q[i] == exp_q[i],
        $sformatf("result %0d is row %0d col %0d addr %h, expected row %0d col %0d addr %h",
          i, res_q[i].row, res_q[i].col, res_q[i].addr,
          exp_q[i].row, exp_q[i].col, exp_q[i].addr));
    end
  endtask

  task automatic run_job(input int m, input int n, input int k, input addr_t base);
    write_reg(REG_M, data_t'(m));
    write_reg(REG_N, data_t'(n));
    write_reg(REG_K, data_t'(k));
    write_reg(REG_BASE, data_t'(base));
    res_q.delete();
    evt_cnt = 0;
    write_reg(REG_TRIGGER, data_t'(1));
  endtask

  task automatic wait_job_end(input int tiles);
    int limit;
    int cycles;
    limit  = tiles * (MAX_K + 1) + N_STALLS * (MAX_STALL + 6) + 20;
    cycles = 0;
    while (evt_cnt == 0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    assert (evt_cnt != 0) else begin
      $display("Job did not signal its end within %0d cycles", limit);
      errors++;
    end
    // Room for a stray second event
    repeat (4) @(negedge clk);
  endtask

  task automatic test_reset_and_regs();
    check_that(!busy && !evt && !result_valid, "outputs not idle after reset");
    write_reg(REG_M, 32'd3);
    write_reg(REG_N, 32'd5);
    write_reg(REG_K, 32'd7);
    write_reg(REG_BASE, 32'h1234_5640);
    write_reg(REG_TILE_COUNT, 32'hab);
    expect_reg(REG_M, 32'd3, "REG_M");
    expect_reg(REG_N, 32'd5, "REG_N");
    expect_reg(REG_K, 32'd7, "REG_K");
    expect_reg(REG_BASE, 32'h1234_5640, "REG_BASE");
    expect_reg(REG_TILE_COUNT, 32'd0, "REG_TILE_COUNT");
    report_test("reset and registers");
  endtask

  task automatic test_basic_job();
    data_t status;
    build_expected(8, 16, 32'h0001_0000);
    run_job(8, 16, 3, 32'h0001_0000);
    read_reg(REG_STATUS, status);
    check_that(status[0] == 1'b1, "REG_STATUS not busy during the job");
    wait_job_end(4);
    compare_results();
    check_that(evt_cnt == 1, $sformatf("evt_o pulsed %0d times, expected once", evt_cnt));
    check_that(res_at_evt == exp_q.size(), "evt_o came before the last result");
    check_that(busy_at_evt == 1'b0, "busy_o high together with evt_o");
    report_test("job 8x16");
  endtask

  task automatic test_rounded_job();
    int k;
    k = 1 + $unsigned($random(seed)) % MAX_K;
    build_expected(5, 9, 32'h0002_0040);
    run_job(5, 9, k, 32'h0002_0040);
    wait_job_end(4);
    compare_results();
    expect_reg(REG_TILE_COUNT, 32'd4, "REG_TILE_COUNT");
    report_test($sformatf("job 5x9 with K=%0d", k));
  endtask

  task automatic test_stall_job();
    int k;
    k = 1 + $unsigned($random(seed)) % MAX_K;
    build_expected(16, 32, 32'h0003_0000);
    run_job(16, 32, k, 32'h0003_0000);
    for (int s = 0; s < N_STALLS; s++) begin
      repeat (1 + $unsigned($random(seed)) % 6) @(negedge clk);
      stall = 1'b1;
      repeat (1 + $unsigned($random(seed)) % MAX_STALL) @(negedge clk);
      stall = 1'b0;
    end
    wait_job_end(16);
    compare_results();
    report_test("stalled job 16x32");
  endtask

  task automatic test_empty_job();
    run_job(4, 0, 2, 32'h0004_0000);
    wait_job_end(0);
    check_that(res_q.size() == 0, $sformatf("empty job gave %0d results", res_q.size()));
    check_that(evt_cnt == 1, $sformatf("evt_o pulsed %0d times, expected once", evt_cnt));
    expect_reg(REG_TILE_COUNT, 32'd0, "REG_TILE_COUNT");
    report_test("empty job");
  endtask

  task automatic test_soft_clear();
    int n_res;
    run_job(16, 32, MAX_K, 32'h0005_0000);
    // Land the clear a few tiles into the job
    repeat (3 * (MAX_K + 1) + 6) @(negedge clk);
    check_that(busy, "job already over before the soft clear");
    write_reg(REG_SOFT_CLEAR, 32'd1);
    check_that(!busy, "busy_o still high after soft clear");
    n_res = res_q.size();
    check_that(n_res < 16, "all tiles finished before the soft clear");
    // Long enough for the cleared job to have run to its end
    repeat (16 * (MAX_K + 1) + 20) @(negedge clk);
    check_that(evt_cnt == 0, "evt_o pulsed after soft clear");
    check_that(res_q.size() == n_res, "results kept coming after soft clear");
    expect_reg(REG_STATUS, 32'd0, "REG_STATUS");
    build_expected(8, 16, 32'h0006_0100);
    run_job(8, 16, 2, 32'h0006_0100);
    wait_job_end(4);
    compare_results();
    check_that(evt_cnt == 1, $sformatf("evt_o pulsed %0d times, expected once", evt_cnt));
    report_test("soft clear");
  endtask

  initial begin
    rst_n         = 1'b0;
    stall         = 1'b0;
    bus_req       = '0;
    seed          = 22;
    evt_cnt       = 0;
    res_at_evt    = 0;
    busy_at_evt   = 1'b0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    test_err_base = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_and_regs();
    test_basic_job();
    test_rounded_job();
    test_stall_job();
    test_empty_job();
    test_soft_clear();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tile_accel_top.f */
+incdir+hdl
hdl/tile_bus_pkg.sv
hdl/tile_job_pkg.sv
hdl/tile_regfile.sv
hdl/tile_ctrl_fsm.sv
hdl/tile_cmd_gen.sv
hdl/tile_cmd_fifo.sv
hdl/tile_engine.sv
hdl/tile_accel_top.sv
dv/tile_accel_tb.sv
